//--- tb.f
common/rv_core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_bank.sv
rtl/execute_stage.sv
rtl/rv_core.sv
tb/program_memory.sv
tb/rv_core_tb.sv

//--- tb/rv_core_tb.sv
/*
 * rv_core testbench.
 * runs a small program under random stall and checks the sequence of stores.
 */
`default_nettype none

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] reset_address  = 32'h0000_0200;
    localparam int          program_length = 36;
    localparam int          store_count    = 14;
    localparam int          store_timeout  = 200;
    localparam int          drain_cycles   = 60;
    localparam logic [31:0] value_a        = 32'h0000_0006;
    localparam logic [31:0] value_b        = 32'hffff_fffb;
    localparam logic [19:0] lui_upper      = 20'h12345;
    localparam logic [11:0] lui_lower      = 12'h678;
    localparam logic [31:0] loop_start     = 32'd3;
    localparam logic [6:0]  op_imm         = 7'b0010011;
    localparam logic [6:0]  op_load        = 7'b0000011;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        stall = 1'b0;
    logic        stall_random = 1'b0;
    integer      seed = 47364;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] instruction;
    logic [31:0] load_data;
    logic [31:0] instruction_address;
    logic        mem_operation_enable;
    logic        mem_write_enable;
    logic [31:0] mem_address;
    logic [31:0] mem_write_data;
    logic        store_valid;
    logic [31:0] store_address;
    logic [31:0] store_data;
    logic [31:0] lui_value;
    logic [31:0] program_words [0:program_length-1];
    logic [31:0] expected_address [0:store_count-1];
    logic [31:0] expected_data [0:store_count-1];

    rv_core #(
        .reset_address          (reset_address)
    ) rv_core_inst (
        .clk                    (clk),
        .reset                  (reset),
        .stall_i                (stall),
        .instruction_i          (instruction),
        .mem_data_i             (load_data),
        .instruction_address_o  (instruction_address),
        .mem_operation_enable_o (mem_operation_enable),
        .mem_write_enable_o     (mem_write_enable),
        .mem_address_o          (mem_address),
        .mem_data_o             (mem_write_data)
    );

    program_memory #(
        .rom_base               (reset_address)
    ) program_memory_inst (
        .clk                    (clk),
        .stall_i                (stall),
        .instruction_address_i  (instruction_address),
        .mem_operation_enable_i (mem_operation_enable),
        .mem_write_enable_i     (mem_write_enable),
        .mem_address_i          (mem_address),
        .mem_data_i             (mem_write_data),
        .instruction_o          (instruction),
        .mem_data_o             (load_data),
        .store_valid_o          (store_valid),
        .store_address_o        (store_address),
        .store_data_o           (store_data)
    );

    always #2 clk = ~clk;

    // about one cycle in four is frozen.
    always @(posedge clk) begin
        if (stall_random) begin
            stall <= (($random(seed) & 3) == 0);
        end else begin
            stall <= 1'b0;
        end
    end

    function automatic logic [31:0] itype(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] funct3, logic [4:0] rd, logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] rtype(logic [6:0] funct7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] funct3, logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] stype(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(logic [12:0] offset, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] funct3);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jtype(logic [20:0] offset, logic [4:0] rd);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, 7'b1101111};
    endfunction

    // alu group on a and b, each result stored right after it.
    task automatic build_program();
        program_words[0]  = itype(value_a[11:0], 5'd0, 3'd0, 5'd1, op_imm);
        program_words[1]  = itype(value_b[11:0], 5'd0, 3'd0, 5'd2, op_imm);
        program_words[2]  = rtype(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
        program_words[3]  = stype(12'h100, 5'd3, 5'd0);
        program_words[4]  = rtype(7'h20, 5'd2, 5'd1, 3'd0, 5'd4);
        program_words[5]  = stype(12'h104, 5'd4, 5'd0);
        program_words[6]  = rtype(7'h00, 5'd2, 5'd1, 3'd7, 5'd5);
        program_words[7]  = stype(12'h108, 5'd5, 5'd0);
        program_words[8]  = rtype(7'h00, 5'd2, 5'd1, 3'd6, 5'd6);
        program_words[9]  = stype(12'h10c, 5'd6, 5'd0);
        program_words[10] = rtype(7'h00, 5'd2, 5'd1, 3'd4, 5'd7);
        program_words[11] = stype(12'h110, 5'd7, 5'd0);
        // slt and sltu compare b against a.
        program_words[12] = rtype(7'h00, 5'd1, 5'd2, 3'd2, 5'd8);
        program_words[13] = rtype(7'h00, 5'd1, 5'd2, 3'd3, 5'd9);
        program_words[14] = stype(12'h114, 5'd8, 5'd0);
        program_words[15] = stype(12'h118, 5'd9, 5'd0);
        // lui, addi, store, then load and use at once.
        program_words[16] = {lui_upper, 5'd10, 7'b0110111};
        program_words[17] = itype(lui_lower, 5'd10, 3'd0, 5'd10, op_imm);
        program_words[18] = stype(12'h11c, 5'd10, 5'd0);
        program_words[19] = itype(12'h11c, 5'd0, 3'd2, 5'd11, op_load);
        program_words[20] = itype(12'h001, 5'd11, 3'd0, 5'd11, op_imm);
        program_words[21] = stype(12'h120, 5'd11, 5'd0);
        // countdown loop closed by bne.
        program_words[22] = itype(loop_start[11:0], 5'd0, 3'd0, 5'd12, op_imm);
        program_words[23] = stype(12'h124, 5'd12, 5'd0);
        program_words[24] = itype(12'hfff, 5'd12, 3'd0, 5'd12, op_imm);
        program_words[25] = btype(-13'd8, 5'd0, 5'd12, 3'd1);
        // taken beq and jal each skip two stores.
        program_words[26] = btype(13'd12, 5'd0, 5'd12, 3'd0);
        program_words[27] = stype(12'h128, 5'd1, 5'd0);
        program_words[28] = stype(12'h128, 5'd2, 5'd0);
        program_words[29] = jtype(21'd12, 5'd13);
        program_words[30] = stype(12'h12c, 5'd1, 5'd0);
        program_words[31] = stype(12'h12c, 5'd2, 5'd0);
        program_words[32] = stype(12'h130, 5'd13, 5'd0);
        program_words[33] = btype(13'd8, 5'd1, 5'd1, 3'd1);
        program_words[34] = stype(12'h134, 5'd1, 5'd0);
        program_words[35] = jtype(21'd0, 5'd0);
    endtask

    task automatic build_expected();
        lui_value = {lui_upper, 12'h000} + {20'h0, lui_lower};
        expected_address[0] = 32'h100;
        expected_data[0]    = value_a + value_b;
        expected_address[1] = 32'h104;
        expected_data[1]    = value_a - value_b;
        expected_address[2] = 32'h108;
        expected_data[2]    = value_a & value_b;
        expected_address[3] = 32'h10c;
        expected_data[3]    = value_a | value_b;
        expected_address[4] = 32'h110;
        expected_data[4]    = value_a ^ value_b;
        expected_address[5] = 32'h114;
        expected_data[5]    = {31'b0, $signed(value_b) < $signed(value_a)};
        expected_address[6] = 32'h118;
        expected_data[6]    = {31'b0, value_b < value_a};
        expected_address[7] = 32'h11c;
        expected_data[7]    = lui_value;
        expected_address[8] = 32'h120;
        expected_data[8]    = lui_value + 32'd1;
        for (int k = 0; k < 3; k++) begin
            expected_address[9 + k] = 32'h124;
            expected_data[9 + k]    = loop_start - k;
        end
        // link value of the jal at word 29.
        expected_address[12] = 32'h130;
        expected_data[12]    = reset_address + 32'd29 * 4 + 32'd4;
        expected_address[13] = 32'h134;
        expected_data[13]    = value_a;
    endtask

    task automatic check_reset_state();
        checks++;
        if (instruction_address !== reset_address) begin
            errors++;
            $display("** Error: instruction_address_o = 0x%08h, expected 0x%08h",
                     instruction_address, reset_address);
        end
        checks++;
        if (mem_operation_enable !== 1'b0 || mem_write_enable !== 1'b0) begin
            errors++;
            $display("** Error: mem_operation_enable_o = 0x%0h, mem_write_enable_o = 0x%0h, %s",
                     mem_operation_enable, mem_write_enable, "expected 0x0");
        end
    endtask

    task automatic wait_for_store(input int index);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (store_valid !== 1'b1 && cycles < store_timeout) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        if (store_valid !== 1'b1) begin
            errors++;
            $display("store %0d did not arrive within %0d cycles", index, store_timeout);
        end else begin
            if (store_address !== expected_address[index]) begin
                errors++;
                $display("** Error: mem_address_o = 0x%08h, expected 0x%08h (store %0d)",
                         store_address, expected_address[index], index);
            end
            if (store_data !== expected_data[index]) begin
                errors++;
                $display("** Error: mem_data_o = 0x%08h, expected 0x%08h (store %0d)",
                         store_data, expected_data[index], index);
            end
        end
    endtask

    // the program ends in a jal to itself.
    task automatic check_no_extra_stores();
        checks++;
        for (int c = 0; c < drain_cycles; c++) begin
            @(negedge clk);
            if (store_valid === 1'b1) begin
                errors++;
                $display("an extra store to 0x%08h with data 0x%08h came after the last one",
                         store_address, store_data);
            end
        end
    endtask

    initial begin
        build_program();
        build_expected();
        @(negedge clk);
        for (int k = 0; k < program_length; k++) begin
            program_memory_inst.rom[k] = program_words[k];
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_reset_state();
        stall_random = 1'b1;
        for (int k = 0; k < store_count; k++) begin
            wait_for_store(k);
        end
        check_no_extra_stores();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/program_memory.sv
/*
 * program memory model.
 * synchronous instruction rom and data ram that reports every accepted store.
 */
`default_nettype none

module program_memory #(
    parameter logic [31:0] rom_base = 32'h0
) (
    input  wire         clk,
    input  wire         stall_i,
    input  wire  [31:0] instruction_address_i,
    input  wire         mem_operation_enable_i,
    input  wire         mem_write_enable_i,
    input  wire  [31:0] mem_address_i,
    input  wire  [31:0] mem_data_i,
    output logic [31:0] instruction_o,
    output logic [31:0] mem_data_o,
    output logic        store_valid_o,
    output logic [31:0] store_address_o,
    output logic [31:0] store_data_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] rom [0:63];
    logic [31:0] ram [0:63];
    logic [31:0] rom_offset;

    // rom words are addi x0 nops with the word index as immediate.
    // ram words carry their own index.
    initial begin
        instruction_o = 32'h0000_0013;
        mem_data_o    = '0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = 32'h0000_0013 | (i << 20);
            ram[i] = 32'hd00d_0000 | i;
        end
    end

    assign rom_offset = instruction_address_i - rom_base;

    always @(posedge clk) begin
        instruction_o <= rom[rom_offset[7:2]];
    end

    // requests count only while the core is not frozen.
    always @(posedge clk) begin
        store_valid_o <= 1'b0;
        if (!stall_i && mem_operation_enable_i) begin
            if (mem_write_enable_i) begin
                ram[mem_address_i[7:2]] <= mem_data_i;
                store_valid_o           <= 1'b1;
                store_address_o         <= mem_address_i;
                store_data_o            <= mem_data_i;
            end else begin
                mem_data_o <= ram[mem_address_i[7:2]];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
/*
 * rv_core top level.
 * connects fetch, decode, register bank and execute of the pipeline.
 */
`default_nettype none

module rv_core #(
    parameter rv_core_pkg::word_t reset_address = '0
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     stall_i,
    input  wire rv_core_pkg::word_t instruction_i,
    input  wire rv_core_pkg::word_t mem_data_i,
    output rv_core_pkg::word_t      instruction_address_o,
    output logic                    mem_operation_enable_o,
    output logic                    mem_write_enable_o,
    output rv_core_pkg::word_t      mem_address_o,
    output rv_core_pkg::word_t      mem_data_o
);

    logic                   hazard;
    logic                   jump;
    rv_core_pkg::word_t     jump_target;
    rv_core_pkg::word_t     pc_decode;
    rv_core_pkg::tag_t      tag_decode;
    rv_core_pkg::reg_addr_t rs1;
    rv_core_pkg::reg_addr_t rs2;
    rv_core_pkg::word_t     rs1_data;
    rv_core_pkg::word_t     rs2_data;
    rv_core_pkg::reg_addr_t rd_execute;
    rv_core_pkg::word_t     first_operand;
    rv_core_pkg::word_t     second_operand;
    rv_core_pkg::word_t     third_operand;
    rv_core_pkg::word_t     pc_execute;
    rv_core_pkg::tag_t      tag_execute;
    rv_core_pkg::op_e       operation_execute;
    rv_core_pkg::reg_addr_t rd_retire;
    logic                   write_enable_retire;
    logic                   load_retire;
    rv_core_pkg::word_t     result_retire;

    fetch_stage #(
        .reset_address          (reset_address)
    ) fetch_stage_inst (
        .clk                    (clk),
        .reset                  (reset),
        .stall_i                (stall_i),
        .hazard_i               (hazard),
        .jump_i                 (jump),
        .jump_target_i          (jump_target),
        .instruction_address_o  (instruction_address_o),
        .pc_o                   (pc_decode),
        .tag_o                  (tag_decode)
    );

    decode_stage decode_stage_inst (
        .clk                    (clk),
        .reset                  (reset),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .pc_i                   (pc_decode),
        .tag_i                  (tag_decode),
        .rs1_data_i             (rs1_data),
        .rs2_data_i             (rs2_data),
        .rs1_o                  (rs1),
        .rs2_o                  (rs2),
        .rd_o                   (rd_execute),
        .first_operand_o        (first_operand),
        .second_operand_o       (second_operand),
        .third_operand_o        (third_operand),
        .pc_o                   (pc_execute),
        .tag_o                  (tag_execute),
        .operation_o            (operation_execute),
        .hazard_o               (hazard)
    );

    register_bank register_bank_inst (
        .clk                    (clk),
        .reset                  (reset),
        .rs1_i                  (rs1),
        .rs2_i                  (rs2),
        .rd_i                   (rd_retire),
        .write_enable_i         (write_enable_retire),
        .load_i                 (load_retire),
        .result_i               (result_retire),
        .mem_data_i             (mem_data_i),
        .rs1_data_o             (rs1_data),
        .rs2_data_o             (rs2_data)
    );

    execute_stage execute_stage_inst (
        .clk                    (clk),
        .reset                  (reset),
        .stall_i                (stall_i),
        .rd_i                   (rd_execute),
        .first_operand_i        (first_operand),
        .second_operand_i       (second_operand),
        .third_operand_i        (third_operand),
        .pc_i                   (pc_execute),
        .tag_i                  (tag_execute),
        .operation_i            (operation_execute),
        .rd_o                   (rd_retire),
        .write_enable_o         (write_enable_retire),
        .load_o                 (load_retire),
        .result_o               (result_retire),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o),
        .jump_o                 (jump),
        .jump_target_o          (jump_target)
    );

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
/*
 * execute stage.
 * alu, branch resolution, memory request and the retire register.
 */
`default_nettype none

module execute_stage (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         stall_i,
    input  wire rv_core_pkg::reg_addr_t rd_i,
    input  wire rv_core_pkg::word_t     first_operand_i,
    input  wire rv_core_pkg::word_t     second_operand_i,
    input  wire rv_core_pkg::word_t     third_operand_i,
    input  wire rv_core_pkg::word_t     pc_i,
    input  wire rv_core_pkg::tag_t      tag_i,
    input  wire rv_core_pkg::op_e       operation_i,
    output rv_core_pkg::reg_addr_t      rd_o,
    output logic                        write_enable_o,
    output logic                        load_o,
    output rv_core_pkg::word_t          result_o,
    output logic                        mem_operation_enable_o,
    output logic                        mem_write_enable_o,
    output rv_core_pkg::word_t          mem_address_o,
    output rv_core_pkg::word_t          mem_data_o,
    output logic                        jump_o,
    output rv_core_pkg::word_t          jump_target_o
);

    rv_core_pkg::tag_t  current_tag;
    logic               killed;
    logic               equal;
    rv_core_pkg::word_t sum;
    rv_core_pkg::word_t alu_result;
    logic               write_enable_q;

    // follows the fetch tag, both bump on the same jump.
    assign killed = (tag_i != current_tag);
    assign sum    = first_operand_i + second_operand_i;
    assign equal  = (first_operand_i == second_operand_i);

    // lui, lw and sw go through the adder with a zero or base operand.
    always_comb begin
        case (operation_i)
            rv_core_pkg::op_sub:  alu_result = first_operand_i - second_operand_i;
            rv_core_pkg::op_and:  alu_result = first_operand_i & second_operand_i;
            rv_core_pkg::op_or:   alu_result = first_operand_i | second_operand_i;
            rv_core_pkg::op_xor:  alu_result = first_operand_i ^ second_operand_i;
            rv_core_pkg::op_slt:
                alu_result = rv_core_pkg::word_t'($signed(first_operand_i) <
                                                  $signed(second_operand_i));
            rv_core_pkg::op_sltu:
                alu_result = rv_core_pkg::word_t'(first_operand_i < second_operand_i);
            rv_core_pkg::op_jal:  alu_result = pc_i + 32'd4;
            default:              alu_result = sum;
        endcase
    end

    assign jump_o = !killed && ((operation_i == rv_core_pkg::op_jal) ||
                                (operation_i == rv_core_pkg::op_beq && equal) ||
                                (operation_i == rv_core_pkg::op_bne && !equal));
    assign jump_target_o = pc_i + third_operand_i;

    assign mem_address_o          = sum;
    assign mem_data_o             = third_operand_i;
    assign mem_operation_enable_o = !killed && (operation_i == rv_core_pkg::op_lw ||
                                                operation_i == rv_core_pkg::op_sw);
    assign mem_write_enable_o     = !killed && (operation_i == rv_core_pkg::op_sw);

    always_ff @(posedge clk) begin
        if (reset) begin
            current_tag    <= '0;
            write_enable_q <= 1'b0;
            load_o         <= 1'b0;
        end else if (!stall_i) begin
            if (jump_o) begin
                current_tag <= current_tag + 1'b1;
            end
            // decode only passes a nonzero rd for writing operations.
            write_enable_q <= !killed && (rd_i != '0);
            load_o         <= !killed && (operation_i == rv_core_pkg::op_lw);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            rd_o     <= rd_i;
            result_o <= alu_result;
        end
    end

    // the bank holds while the pipeline is frozen.
    assign write_enable_o = write_enable_q && !stall_i;

endmodule

`default_nettype wire

//--- rtl/register_bank.sv
/*
 * register bank.
 * x1..x31 with retire data selection and write-back bypass.
 */
`default_nettype none

module register_bank (
    input  wire                         clk,
    input  wire                         reset,
    input  wire rv_core_pkg::reg_addr_t rs1_i,
    input  wire rv_core_pkg::reg_addr_t rs2_i,
    input  wire rv_core_pkg::reg_addr_t rd_i,
    input  wire                         write_enable_i,
    input  wire                         load_i,
    input  wire rv_core_pkg::word_t     result_i,
    input  wire rv_core_pkg::word_t     mem_data_i,
    output rv_core_pkg::word_t          rs1_data_o,
    output rv_core_pkg::word_t          rs2_data_o
);

    rv_core_pkg::word_t registers [1:31];
    rv_core_pkg::word_t retire_data;
    logic               writing;

    // load data arrives from memory during the retire cycle.
    assign retire_data = load_i ? mem_data_i : result_i;
    assign writing     = write_enable_i && (rd_i != '0);

    function automatic rv_core_pkg::word_t read_port(rv_core_pkg::reg_addr_t addr);
        if (addr == '0) begin
            read_port = '0;
        end else if (writing && addr == rd_i) begin
            read_port = retire_data;
        end else begin
            read_port = registers[addr];
        end
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (writing) begin
            registers[rd_i] <= retire_data;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
/*
 * decode stage.
 * decodes the instruction, reads operands and inserts bubbles on hazards.
 */
`default_nettype none

module decode_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     stall_i,
    input  wire rv_core_pkg::word_t instruction_i,
    input  wire rv_core_pkg::word_t pc_i,
    input  wire rv_core_pkg::tag_t  tag_i,
    input  wire rv_core_pkg::word_t rs1_data_i,
    input  wire rv_core_pkg::word_t rs2_data_i,
    output rv_core_pkg::reg_addr_t  rs1_o,
    output rv_core_pkg::reg_addr_t  rs2_o,
    output rv_core_pkg::reg_addr_t  rd_o,
    output rv_core_pkg::word_t      first_operand_o,
    output rv_core_pkg::word_t      second_operand_o,
    output rv_core_pkg::word_t      third_operand_o,
    output rv_core_pkg::word_t      pc_o,
    output rv_core_pkg::tag_t       tag_o,
    output rv_core_pkg::op_e        operation_o,
    output logic                    hazard_o
);

    rv_core_pkg::word_t     instr_hold;
    logic                   use_hold;
    logic                   fetched;
    rv_core_pkg::tag_t      instr_tag;
    rv_core_pkg::word_t     instr;
    logic [6:0]             opcode;
    rv_core_pkg::op_e       operation;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::word_t     imm_i;
    rv_core_pkg::word_t     imm_s;
    rv_core_pkg::word_t     imm_b;
    rv_core_pkg::word_t     imm_u;
    rv_core_pkg::word_t     imm_j;
    logic                   uses_rs1;
    logic                   uses_rs2;
    logic                   valid;
    logic                   consume;

    function automatic rv_core_pkg::op_e alu_op(logic [2:0] funct3, logic subtract);
        case (funct3)
            rv_core_pkg::funct3_add_sub:
                alu_op = subtract ? rv_core_pkg::op_sub : rv_core_pkg::op_add;
            rv_core_pkg::funct3_slt:  alu_op = rv_core_pkg::op_slt;
            rv_core_pkg::funct3_sltu: alu_op = rv_core_pkg::op_sltu;
            rv_core_pkg::funct3_xor:  alu_op = rv_core_pkg::op_xor;
            rv_core_pkg::funct3_or:   alu_op = rv_core_pkg::op_or;
            rv_core_pkg::funct3_and:  alu_op = rv_core_pkg::op_and;
            default:                  alu_op = rv_core_pkg::op_nop;
        endcase
    endfunction

    // the rom already moved on, so a held instruction is replayed from here.
    assign instr  = use_hold ? instr_hold : instruction_i;
    assign opcode = instr[6:0];
    assign rs1_o  = instr[19:15];
    assign rs2_o  = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            rv_core_pkg::opcode_lui:    operation = rv_core_pkg::op_lui;
            rv_core_pkg::opcode_op:     operation = alu_op(instr[14:12], instr[30]);
            rv_core_pkg::opcode_op_imm: operation = alu_op(instr[14:12], 1'b0);
            rv_core_pkg::opcode_jal:    operation = rv_core_pkg::op_jal;
            rv_core_pkg::opcode_load:
                operation = (instr[14:12] == rv_core_pkg::funct3_word) ?
                            rv_core_pkg::op_lw : rv_core_pkg::op_nop;
            rv_core_pkg::opcode_store:
                operation = (instr[14:12] == rv_core_pkg::funct3_word) ?
                            rv_core_pkg::op_sw : rv_core_pkg::op_nop;
            rv_core_pkg::opcode_branch:
                if (instr[14:12] == rv_core_pkg::funct3_beq) begin
                    operation = rv_core_pkg::op_beq;
                end else if (instr[14:12] == rv_core_pkg::funct3_bne) begin
                    operation = rv_core_pkg::op_bne;
                end else begin
                    operation = rv_core_pkg::op_nop;
                end
            default:                    operation = rv_core_pkg::op_nop;
        endcase
    end

    assign uses_rs1 = !(operation inside {rv_core_pkg::op_nop, rv_core_pkg::op_lui,
                                          rv_core_pkg::op_jal});
    assign uses_rs2 = opcode inside {rv_core_pkg::opcode_op, rv_core_pkg::opcode_store,
                                     rv_core_pkg::opcode_branch};

    // stores and branches carry immediate bits in the rd field.
    assign rd = (operation inside {rv_core_pkg::op_nop, rv_core_pkg::op_sw,
                                   rv_core_pkg::op_beq, rv_core_pkg::op_bne}) ?
                '0 : instr[11:7];

    // wrong-path instructions still in flight after a jump are dropped.
    assign valid    = fetched && (instr_tag == tag_i);
    assign hazard_o = valid && (rd_o != '0) &&
                      ((uses_rs1 && rs1_o == rd_o) || (uses_rs2 && rs2_o == rd_o));
    assign consume  = !stall_i && !hazard_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            use_hold  <= 1'b0;
            fetched   <= 1'b0;
            instr_tag <= '0;
        end else if (consume) begin
            use_hold  <= 1'b0;
            fetched   <= 1'b1;
            instr_tag <= tag_i;
        end else begin
            use_hold  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!consume) begin
            instr_hold <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            operation_o <= rv_core_pkg::op_nop;
            rd_o        <= '0;
        end else if (!stall_i) begin
            operation_o <= (valid && !hazard_o) ? operation : rv_core_pkg::op_nop;
            rd_o        <= (valid && !hazard_o) ? rd : '0;
        end
    end

    // operand a, operand b, then store data or jump offset.
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            first_operand_o <= uses_rs1 ? rs1_data_i : '0;
            if (opcode inside {rv_core_pkg::opcode_op, rv_core_pkg::opcode_branch}) begin
                second_operand_o <= rs2_data_i;
            end else if (opcode == rv_core_pkg::opcode_lui) begin
                second_operand_o <= imm_u;
            end else if (opcode == rv_core_pkg::opcode_store) begin
                second_operand_o <= imm_s;
            end else begin
                second_operand_o <= imm_i;
            end
            if (opcode == rv_core_pkg::opcode_store) begin
                third_operand_o <= rs2_data_i;
            end else if (opcode == rv_core_pkg::opcode_jal) begin
                third_operand_o <= imm_j;
            end else begin
                third_operand_o <= imm_b;
            end
            pc_o  <= pc_i;
            tag_o <= instr_tag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
/*
 * fetch stage.
 * program counter, jump redirection and the jump tag.
 */
`default_nettype none

module fetch_stage #(
    parameter rv_core_pkg::word_t reset_address = '0
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     stall_i,
    input  wire                     hazard_i,
    input  wire                     jump_i,
    input  wire rv_core_pkg::word_t jump_target_i,
    output rv_core_pkg::word_t      instruction_address_o,
    output rv_core_pkg::word_t      pc_o,
    output rv_core_pkg::tag_t       tag_o
);

    always_ff @(posedge clk) begin
        if (reset) begin
            instruction_address_o <= reset_address;
            pc_o                  <= reset_address;
            tag_o                 <= '0;
        end else if (!stall_i) begin
            if (jump_i) begin
                instruction_address_o <= jump_target_i;
                tag_o                 <= tag_o + 1'b1;
            end else if (!hazard_i) begin
                instruction_address_o <= instruction_address_o + 32'd4;
            end

            // decode keeps its pc while a bubble is inserted.
            if (jump_i || !hazard_i) begin
                pc_o <= instruction_address_o;
            end
        end
    end

endmodule

`default_nettype wire

//--- common/rv_core_pkg.sv
/*
 * rv_core shared definitions.
 * data widths, operation codes and the RV32I field values the decoder uses.
 */
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // bumped on every taken jump.
    typedef logic [2:0]      tag_t;

    // addi decodes to op_add with an immediate operand.
    typedef enum logic [3:0] {
        op_nop,
        op_lui,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_sltu,
        op_lw,
        op_sw,
        op_beq,
        op_bne,
        op_jal
    } op_e;

    // major opcodes.
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;

    // funct3 of the alu group.
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_slt     = 3'b010;
    localparam logic [2:0] funct3_sltu    = 3'b011;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;

    // funct3 of loads, stores and branches.
    localparam logic [2:0] funct3_word = 3'b010;
    localparam logic [2:0] funct3_beq  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;

endpackage

`default_nettype wire
